/* tb.f */
+incdir+rtl
rtl/mem_arb_pkg.sv
rtl/mem_arbiter.sv
rtl/line_memory.sv
rtl/mem_subsystem_top.sv
bench/clock_gen.sv
bench/mem_arbiter_asserts.sv
bench/tb_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mem_subsystem \
    -Mdir obj_dir -o tb_mem_subsystem_sim \
    && ./obj_dir/tb_mem_subsystem_sim | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* bench/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_config.svh"

module tb_mem_subsystem;

    import mem_arb_pkg::*;

    typedef logic [`MEM_LINE_BITS-1:0]  line_t;
    typedef logic [`MEM_DEPTH_LOG2-1:0] index_t;

    localparam int     random_ops = 200;
    localparam int     total_ops  = 2 * random_ops + 12;  // A paired request counts twice
    localparam int     timeout    = (total_ops * (`MEM_LATENCY + 4) + 50) * 100;

    logic        clk;
    logic        rst_n;
    mem_addr_t   icache_address;
    mem_addr_t   dcache_address;
    logic        icache_req;
    logic        dcache_req;
    logic        wr_en;
    line_t       data_in;
    line_t       icache_data_out;
    line_t       dcache_data_out;
    logic        icache_operation_complete;
    logic        dcache_operation_complete;

    logic [31:0] lfsr;
    int          cycle;
    line_t       ref_mem [1 << `MEM_DEPTH_LOG2];
    index_t      written [$];  // Lines that reads may target
    line_t       i_exp_line [$];
    int          i_exp_cycle [$];
    line_t       d_exp_line [$];
    int          d_exp_cycle [$];

    clock_gen clock_i (.clk(clk), .rst_n(rst_n));

    mem_subsystem_top dut_i (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .icache_address            (icache_address),
        .dcache_address            (dcache_address),
        .icache_req                (icache_req),
        .dcache_req                (dcache_req),
        .wr_en                     (wr_en),
        .data_in                   (data_in),
        .icache_data_out           (icache_data_out),
        .dcache_data_out           (dcache_data_out),
        .icache_operation_complete (icache_operation_complete),
        .dcache_operation_complete (dcache_operation_complete)
    );

    // ##########################################################################
    // Random source and reference model
    // ##########################################################################

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32+x^22+x^2+x+1
            lfsr     = {lfsr[30:0], feedback};
            value    = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic line_t random_line();
        line_t line;
        int    w;
        for (w = 0; w < `MEM_LINE_BITS / 32; w++) begin
            line[w*32 +: 32] = random_bits(32);
        end
        return line;
    endfunction

    // Random upper line bits and offset since the memory only decodes the low line bits
    function automatic mem_addr_t random_address(input index_t index);
        mem_addr_t   addr;
        logic [31:0] high;
        logic [31:0] low;
        high      = random_bits(32);
        low       = random_bits(32);
        addr.word = {high, low};
        addr.fields.line_number[`MEM_DEPTH_LOG2-1:0] = index;
        return addr;
    endfunction

    function automatic index_t line_index(input mem_addr_t addr);
        return addr.fields.line_number[`MEM_DEPTH_LOG2-1:0];
    endfunction

    function automatic index_t pick_written();
        int pos;
        pos = int'(random_bits(16)) % written.size();
        return written[pos];
    endfunction

    // A write returns the stored line and a read returns the line last written there
    function automatic line_t expected_line(input logic is_write, input index_t index,
                                            input line_t line);
        return is_write ? line : ref_mem[index];
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check(input line_t actual, input line_t expected, input string what);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %0d ns %s: got %0h, expected %0h",
                                     $time, what, actual, expected));
        end
    endtask

    // ##########################################################################
    // Cache side driver that holds requests level until one edge past completion
    // ##########################################################################

    task automatic run_transaction(input logic use_i, input mem_addr_t i_addr,
                                   input logic use_d, input mem_addr_t d_addr,
                                   input logic d_write, input line_t d_line);
        int   start;
        logic i_open;
        logic d_open;
        logic i_seen;
        logic d_seen;
        @(negedge clk);
        start = cycle;
        if (use_i) begin
            i_exp_line.push_back(expected_line(1'b0, line_index(i_addr), '0));
            i_exp_cycle.push_back(start + `MEM_LATENCY + 2);
        end
        if (use_d) begin
            d_exp_line.push_back(expected_line(d_write, line_index(d_addr), d_line));
            d_exp_cycle.push_back(start + `MEM_LATENCY + 2 + (use_i ? `MEM_LATENCY + 3 : 0));
            if (d_write) begin
                ref_mem[line_index(d_addr)] = d_line;
                written.push_back(line_index(d_addr));
            end
        end
        icache_address = i_addr;
        icache_req     = use_i;
        dcache_address = d_addr;
        dcache_req     = use_d;
        wr_en          = use_d && d_write;
        data_in        = d_line;
        i_open         = use_i;
        d_open         = use_d;
        i_seen         = 1'b0;
        d_seen         = 1'b0;
        while (i_open || d_open) begin
            @(negedge clk);
            if (i_open && i_seen) begin
                icache_req = 1'b0;
                i_open     = 1'b0;
            end else if (i_open && icache_operation_complete) begin
                i_seen = 1'b1;  // Cache samples it on the next rising edge
            end
            if (d_open && d_seen) begin
                dcache_req = 1'b0;
                wr_en      = 1'b0;
                d_open     = 1'b0;
            end else if (d_open && dcache_operation_complete) begin
                d_seen = 1'b1;
            end
        end
    endtask

    // ##########################################################################
    // Checker, cycle count and watchdog
    // ##########################################################################

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    always @(negedge clk) begin
        if (rst_n && icache_operation_complete) begin
            if (i_exp_line.size() == 0) begin
                report_failure("Instruction cache completed with no request outstanding");
            end else begin
                check(icache_data_out, i_exp_line.pop_front(), "icache line");
                check(line_t'(cycle), line_t'(i_exp_cycle.pop_front()), "icache cycle");
            end
        end
        if (rst_n && dcache_operation_complete) begin
            if (d_exp_line.size() == 0) begin
                report_failure("Data cache completed with no request outstanding");
            end else begin
                check(dcache_data_out, d_exp_line.pop_front(), "dcache line");
                check(line_t'(cycle), line_t'(d_exp_cycle.pop_front()), "dcache cycle");
            end
        end
    end

    initial begin
        #(timeout);
        report_failure("Watchdog expired before all requests completed");
    end

    initial begin
        mem_addr_t  addr_a;
        mem_addr_t  addr_b;
        mem_addr_t  i_addr;
        mem_addr_t  d_addr;
        line_t      line_a;
        logic [1:0] kind;
        logic       d_write;
        index_t     d_index;
        int         n;
        lfsr           = 32'h3915_d236;
        icache_address = '0;
        dcache_address = '0;
        icache_req     = 1'b0;
        dcache_req     = 1'b0;
        wr_en          = 1'b0;
        data_in        = '0;
        wait (rst_n === 1'b1);
        repeat (4) begin
            @(negedge clk);
            check(icache_data_out | dcache_data_out, '0, "data output while idle");
            check(line_t'({icache_operation_complete, dcache_operation_complete,
                           dut_i.mem_req, dut_i.mem_wr_en, dut_i.mem_data_valid}), '0,
                  "activity while idle");
        end
        line_a = random_line();
        addr_a = random_address(index_t'(5));
        run_transaction(1'b0, addr_a, 1'b1, addr_a, 1'b1, line_a);
        run_transaction(1'b0, addr_a, 1'b1, addr_a, 1'b0, '0);
        run_transaction(1'b1, addr_a, 1'b0, addr_a, 1'b0, '0);
        addr_b = random_address(index_t'(9));
        run_transaction(1'b1, addr_a, 1'b1, addr_b, 1'b1, random_line());
        // Same line through two offsets and different upper bits
        addr_a = random_address(index_t'(20));
        addr_a.fields.byte_offset = 6'd3;
        addr_b = random_address(index_t'(20));
        addr_b.fields.byte_offset = 6'd60;
        run_transaction(1'b0, addr_a, 1'b1, addr_a, 1'b1, random_line());
        run_transaction(1'b1, addr_b, 1'b1, addr_b, 1'b0, '0);
        for (n = 0; n < random_ops; n++) begin
            kind    = 2'(random_bits(2));  // Value 0 asks the icache and 1 the dcache while 2 and 3 ask both
            d_write = random_bits(1) != 0;
            d_index = d_write ? index_t'(random_bits(`MEM_DEPTH_LOG2)) : pick_written();
            i_addr  = random_address(pick_written());
            d_addr  = random_address(d_index);
            line_a  = random_line();
            run_transaction(kind != 2'd1, i_addr, kind != 2'd0, d_addr, d_write, line_a);
        end
        repeat (4) @(negedge clk);
        if (i_exp_line.size() == 0 && d_exp_line.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            report_failure("Completions still outstanding at end of run");
        end
    end

endmodule

`default_nettype wire

/* bench/mem_arbiter_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter_asserts (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic                icache_req,
    input wire logic                dcache_req,
    input wire logic                mem_req,
    input wire logic                icache_operation_complete,
    input wire logic                dcache_operation_complete,
    input wire mem_arb_pkg::owner_t owner
);

    import mem_arb_pkg::*;

    mem_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |=> !mem_req)
        else $error("mem_req stayed high for more than one cycle");

    complete_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(icache_operation_complete && dcache_operation_complete))
        else $error("Both completions high in the same cycle");

    // ##########################################################################
    // Completion goes to the cache that owns the port and still asks
    // ##########################################################################

    icache_complete_owned: assert property (@(posedge clk) disable iff (!rst_n)
        icache_operation_complete |-> icache_req && owner == owner_icache)
        else $error("Instruction cache completion without its request");

    dcache_complete_owned: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_operation_complete |-> dcache_req && owner == owner_dcache)
        else $error("Data cache completion without its request");

    icache_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(icache_req) |-> $past(icache_operation_complete))
        else $error("Instruction cache request dropped before completion");

    dcache_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(dcache_req) |-> $past(dcache_operation_complete))
        else $error("Data cache request dropped before completion");

endmodule

bind mem_arbiter mem_arbiter_asserts asserts_i (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .icache_req                (icache_req),
    .dcache_req                (dcache_req),
    .mem_req                   (mem_req),
    .icache_operation_complete (icache_operation_complete),
    .dcache_operation_complete (dcache_operation_complete),
    .owner                     (owner)
);

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Released away from the active edge
    end

endmodule

`default_nettype wire

/* rtl/mem_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_config.svh"

module mem_subsystem_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,

    input  wire mem_arb_pkg::mem_addr_t    icache_address,
    input  wire mem_arb_pkg::mem_addr_t    dcache_address,
    input  wire logic                      icache_req,
    input  wire logic                      dcache_req,
    input  wire logic                      wr_en,
    input  wire logic [`MEM_LINE_BITS-1:0] data_in,

    output wire logic [`MEM_LINE_BITS-1:0] icache_data_out,
    output wire logic [`MEM_LINE_BITS-1:0] dcache_data_out,
    output wire logic                      icache_operation_complete,
    output wire logic                      dcache_operation_complete
);

    import mem_arb_pkg::*;

    // ######################################################################
    // Arbiter to memory controller link
    // ######################################################################

    wire mem_addr_t                 mem_address;
    wire logic [`MEM_LINE_BITS-1:0] mem_data_out;
    wire logic                      mem_req;
    wire logic                      mem_wr_en;
    wire logic [`MEM_LINE_BITS-1:0] data_from_mem;
    wire logic                      mem_data_valid;

    mem_arbiter arbiter_i (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .icache_address            (icache_address),
        .dcache_address            (dcache_address),
        .icache_req                (icache_req),
        .dcache_req                (dcache_req),
        .wr_en                     (wr_en),
        .data_in                   (data_in),
        .icache_data_out           (icache_data_out),
        .dcache_data_out           (dcache_data_out),
        .icache_operation_complete (icache_operation_complete),
        .dcache_operation_complete (dcache_operation_complete),
        .data_from_mem             (data_from_mem),
        .mem_data_valid            (mem_data_valid),
        .mem_address               (mem_address),
        .mem_data_out              (mem_data_out),
        .mem_req                   (mem_req),
        .mem_wr_en                 (mem_wr_en)
    );

    line_memory memory_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_address    (mem_address),
        .mem_data_out   (mem_data_out),
        .mem_req        (mem_req),
        .mem_wr_en      (mem_wr_en),
        .data_from_mem  (data_from_mem),
        .mem_data_valid (mem_data_valid)
    );

endmodule

`default_nettype wire

/* rtl/line_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_config.svh"

module line_memory (
    input  wire logic                      clk,
    input  wire logic                      rst_n,

    input  wire mem_arb_pkg::mem_addr_t    mem_address,
    input  wire logic [`MEM_LINE_BITS-1:0] mem_data_out,
    input  wire logic                      mem_req,
    input  wire logic                      mem_wr_en,

    output logic [`MEM_LINE_BITS-1:0]      data_from_mem,
    output logic                           mem_data_valid
);

    localparam int mem_depth = 1 << `MEM_DEPTH_LOG2;
    localparam int cnt_bits  = $clog2(`MEM_LATENCY + 1);

    logic [`MEM_LINE_BITS-1:0] mem_array [mem_depth];

    logic [`MEM_DEPTH_LOG2-1:0] req_index;
    logic [`MEM_DEPTH_LOG2-1:0] pend_index;
    logic                       pend_wr;
    logic [`MEM_LINE_BITS-1:0]  pend_data;
    logic [cnt_bits-1:0]        count;
    logic                       fire;

    // Only the low line-number bits select a line and the byte offset is dropped
    assign req_index = mem_address.fields.line_number[`MEM_DEPTH_LOG2-1:0];

    assign fire = (count == cnt_bits'(1));  // Last latency cycle of the access

    // ######################################################################
    // Request capture
    // ######################################################################

    always_ff @(posedge clk) begin
        if (mem_req) begin
            pend_index <= req_index;
            pend_wr    <= mem_wr_en;
            pend_data  <= mem_data_out;
        end
    end

    // ######################################################################
    // Latency counter and return
    // ######################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count          <= '0;
            mem_data_valid <= 1'b0;
            data_from_mem  <= '0;
        end else begin
            mem_data_valid <= fire;
            if (mem_req) begin
                count <= cnt_bits'(`MEM_LATENCY - 1);
            end else if (count != '0) begin
                count <= count - cnt_bits'(1);
            end
            if (fire) begin
                // A write hands back the line it stores
                data_from_mem <= pend_wr ? pend_data : mem_array[pend_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && pend_wr) begin
            mem_array[pend_index] <= pend_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_config.svh"

module mem_arbiter (
    input  wire logic                      clk,
    input  wire logic                      rst_n,

    input  wire mem_arb_pkg::mem_addr_t    icache_address,
    input  wire mem_arb_pkg::mem_addr_t    dcache_address,
    input  wire logic                      icache_req,
    input  wire logic                      dcache_req,
    input  wire logic                      wr_en,
    input  wire logic [`MEM_LINE_BITS-1:0] data_in,

    output logic [`MEM_LINE_BITS-1:0]      icache_data_out,
    output logic [`MEM_LINE_BITS-1:0]      dcache_data_out,
    output logic                           icache_operation_complete,
    output logic                           dcache_operation_complete,

    input  wire logic [`MEM_LINE_BITS-1:0] data_from_mem,
    input  wire logic                      mem_data_valid,

    output mem_arb_pkg::mem_addr_t         mem_address,
    output logic [`MEM_LINE_BITS-1:0]      mem_data_out,
    output logic                           mem_req,
    output logic                           mem_wr_en
);

    import mem_arb_pkg::*;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_wait = 2'd1,
        st_done = 2'd2
    } state_t;

    state_t state;
    owner_t owner;
    logic   grant_icache;
    logic   grant_dcache;
    logic   mem_return;

    // ######################################################################
    // Grant decode with fixed instruction cache priority
    // ######################################################################

    assign grant_icache = (state == st_idle) && icache_req;
    assign grant_dcache = (state == st_idle) && !icache_req && dcache_req;
    assign mem_return   = (state == st_wait) && mem_data_valid;

    // ######################################################################
    // Transaction control
    // ######################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state                     <= st_idle;
            owner                     <= owner_none;
            mem_req                   <= 1'b0;
            mem_wr_en                 <= 1'b0;
            icache_operation_complete <= 1'b0;
            dcache_operation_complete <= 1'b0;
        end else begin
            mem_req                   <= 1'b0;  // Request to memory is a single pulse
            icache_operation_complete <= 1'b0;
            dcache_operation_complete <= 1'b0;
            case (state)
                st_idle: begin
                    if (grant_icache) begin
                        owner     <= owner_icache;
                        mem_wr_en <= 1'b0;      // Instruction fetches never write
                        mem_req   <= 1'b1;
                        state     <= st_wait;
                    end else if (grant_dcache) begin
                        owner     <= owner_dcache;
                        mem_wr_en <= wr_en;
                        mem_req   <= 1'b1;
                        state     <= st_wait;
                    end
                end
                st_wait: begin
                    if (mem_data_valid) begin
                        icache_operation_complete <= (owner == owner_icache);
                        dcache_operation_complete <= (owner == owner_dcache);
                        state                     <= st_done;
                    end
                end
                st_done: begin
                    // Caches see completion here and drop their request
                    owner <= owner_none;
                    state <= st_idle;
                end
                default: begin
                    owner <= owner_none;
                    state <= st_idle;
                end
            endcase
        end
    end

    // ######################################################################
    // Returned line steered to its owner
    // ######################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            icache_data_out <= '0;
            dcache_data_out <= '0;
        end else if (mem_return) begin
            if (owner == owner_icache) begin
                icache_data_out <= data_from_mem;
            end else if (owner == owner_dcache) begin
                dcache_data_out <= data_from_mem;
            end
        end
    end

    // Address and write line are held stable for the whole transaction
    always_ff @(posedge clk) begin
        if (grant_icache) begin
            mem_address <= icache_address;
        end else if (grant_dcache) begin
            mem_address <= dcache_address;
            if (wr_en) begin
                mem_data_out <= data_in;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_arb_pkg.sv */
`default_nettype none

`include "mem_arb_config.svh"

package mem_arb_pkg;

    // ######################################################################
    // Address word and its line decode
    // ######################################################################

    typedef struct packed {
        logic [`MEM_ADDR_BITS-`MEM_OFFSET_BITS-1:0] line_number;
        logic [`MEM_OFFSET_BITS-1:0]                byte_offset;
    } mem_line_addr_t;

    typedef union packed {
        logic [`MEM_ADDR_BITS-1:0] word;   // Raw view as seen by the arbiter
        mem_line_addr_t            fields; // Decoded view used by the memory
    } mem_addr_t;

    // ######################################################################
    // Current holder of the memory port
    // ######################################################################

    typedef enum logic [1:0] {
        owner_none   = 2'd0,
        owner_icache = 2'd1,
        owner_dcache = 2'd2
    } owner_t;

endpackage

`default_nettype wire

/* rtl/mem_arb_config.svh */
`ifndef MEM_ARB_CONFIG_SVH
`define MEM_ARB_CONFIG_SVH

// ##########################################################################
// Memory subsystem sizing
// ##########################################################################

// Cache and memory address width
`define MEM_ADDR_BITS   64

// One cache line that moves as a whole
`define MEM_LINE_BITS   512

// Byte offset inside a line of 64 bytes
`define MEM_OFFSET_BITS 6

`define MEM_DEPTH_LOG2  8    // 256 lines with the upper line-number bits aliased

`define MEM_LATENCY     3    // Edges from request sample to valid pulse with a minimum of 2

`endif
